/* all.f */
+incdir+.
rv_pkg.sv
rv_control.sv
rv_regfile.sv
rv_ex_stage.sv
rv_datapath.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# builds and runs the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rv_core -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* tb_rv_core.sv */
`default_nettype none
`include "rv_macros.svh"

module tb_rv_core import rv_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] rom_addr_o;
    logic [31:0] instr_i;
    logic [31:0] ram_addr_o;
    logic [31:0] store_data_o;
    logic [31:0] load_data_i;
    logic        r_en_o;
    logic        w_en_o;
    status_t     status_o;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          plen;
    int          errors;
    int          stalls;
    int          flushes;
    int          loads;
    int          cycles;
    int          budget;
    logic        running;
    status_t     xfer_status;

    rv_core dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rom_addr_o   (rom_addr_o),
        .instr_i      (instr_i),
        .ram_addr_o   (ram_addr_o),
        .store_data_o (store_data_o),
        .load_data_i  (load_data_i),
        .r_en_o       (r_en_o),
        .w_en_o       (w_en_o),
        .status_o     (status_o)
    );

    bind rv_datapath rv_core_props u_props (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .r_en_o    (r_en_o),
        .w_en_o    (w_en_o),
        .status_o  (status_o),
        .pc_q      (pc_q),
        .ex_target (ex_target)
    );

    assign instr_i     = rom[rom_addr_o[9:2]];
    assign load_data_i = ram[ram_addr_o[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ram refilled while reset is held
    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= (i * 32'h9E37_79B9) ^ 32'h5A5A_0000;
            end
        end else if (w_en_o) begin
            ram[ram_addr_o[9:2]] <= store_data_o;
        end
    end

    always @(posedge clk) begin
        if (rst_n_i) begin
            cycles++;
            if (cycles > budget) begin
                $display("timeout: no finish within %0d cycles", budget);
                $display("FAIL: see errors above");
                $finish;
            end
        end
    end

    //////////////////////////////
    // checks

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (running) begin
            if (rom_addr_o[1:0] != 2'b00) begin
                errors++;
                $display("fetch from misaligned address %h at %0t", rom_addr_o, $time);
            end
            if (status_o.stall) stalls++;
            if (r_en_o) loads++;
            if (status_o.flush && exp_addr.size() > 0) begin
                flushes++;
                check_status("status_o", status_o, xfer_status);
            end
            if (w_en_o) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("unexpected store to address %h at %0t", ram_addr_o, $time);
                end else begin
                    check_word("ram_addr_o", ram_addr_o, exp_addr.pop_front());
                    check_word("store_data_o", store_data_o, exp_data.pop_front());
                end
            end
        end
    end

    //////////////////////////////
    // encoding

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[plen] = word;
        plen++;
    endtask

    task automatic store_at(input logic [4:0] rs2, input logic [11:0] addr);
        emit({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'b0100011});
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit({hi[31:12], rd, 7'b0110111});
        emit(i_type(v[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // two nops and a self-jump
    task automatic emit_tail();
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, 7'b0010011));
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, 7'b0010011));
        emit(j_type(21'd0, 5'd0));
    endtask

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'd0, $signed(x) < $signed(y)};
            3'b011:  return {31'd0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                          input logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    //////////////////////////////
    // test flow

    task automatic begin_test();
        @(posedge clk);
        #1 rst_n_i = 1'b0;
        running = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        stalls = 0;
        flushes = 0;
        loads = 0;
        xfer_status = '0;
        plen = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'd0;
        end
    endtask

    task automatic run_program();
        budget += plen * 4;
        repeat (16) begin
            @(negedge clk);
            check_word("rom_addr_o", rom_addr_o, `RV_RESET_PC);
            check_word("r_en_o", {31'd0, r_en_o}, 32'd0);
            check_word("w_en_o", {31'd0, w_en_o}, 32'd0);
            check_status("status_o", status_o, '0);
        end
        @(posedge clk);
        #1 rst_n_i = 1'b1;
        running = 1'b1;
        while (exp_addr.size() > 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
        running = 1'b0;
    endtask

    task automatic alu_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [6:0]  f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                  7'h00, 7'h00, 7'h00, 7'h00, 7'h20};
        logic [2:0]  f3s [10] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                                  3'b010, 3'b011, 3'b001, 3'b101, 3'b101};
        logic [11:0] imms [9] = '{12'h9AB, 12'h9AB, 12'h9AB, 12'h9AB, 12'h9AB,
                                  12'h9AB, 12'h007, 12'h007, 12'h407};
        logic [2:0]  if3s [9] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110,
                                  3'b111, 3'b001, 3'b101, 3'b101};
        logic [11:0] addr;
        begin_test();
        // negative a exercises sra, slt and sltu
        a = $urandom | 32'h8000_0000;
        b = $urandom;
        addr = 12'h100;
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(r_type(f7s[k], 5'd2, 5'd1, f3s[k], 5'd3));
            store_at(5'd3, addr);
            expect_store({20'd0, addr}, ref_alu(f3s[k], f7s[k][5], a, b));
            addr += 12'd4;
        end
        for (int k = 0; k < 9; k++) begin
            emit(i_type(imms[k], 5'd1, if3s[k], 5'd3, 7'b0010011));
            store_at(5'd3, addr);
            expect_store({20'd0, addr},
                         ref_alu(if3s[k], imms[k][10], a, {{20{imms[k][11]}}, imms[k]}));
            addr += 12'd4;
        end
        emit({20'hABCDE, 5'd4, 7'b0110111});
        store_at(5'd4, addr);
        expect_store({20'd0, addr}, 32'hABCD_E000);
        addr += 12'd4;
        // dependent chain through memory and writeback forwarding
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        emit(r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd5));
        emit(r_type(7'h20, 5'd4, 5'd5, 3'b000, 5'd6));
        store_at(5'd6, addr);
        expect_store({20'd0, addr}, a + b);
        emit_tail();
        run_program();
    endtask

    task automatic load_use_test();
        logic [31:0] v;
        begin_test();
        v = $urandom;
        load_const(5'd1, v);
        store_at(5'd1, 12'h040);
        emit(i_type(12'h040, 5'd0, 3'b010, 5'd2, 7'b0000011));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        store_at(5'd3, 12'h044);
        expect_store(32'h40, v);
        expect_store(32'h44, v + v);
        emit_tail();
        run_program();
        check_word("stall count", stalls, 32'd1);
        check_word("load count", loads, 32'd1);
    endtask

    task automatic branch_test();
        logic [2:0]  conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [31:0] vals [3];
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [11:0] base;
        int          taken;
        int          k;
        begin_test();
        vals[1] = 32'hFFFF_FFFB;
        vals[2] = 32'd3;
        taken = 0;
        k = 0;
        load_const(5'd1, vals[1]);
        load_const(5'd2, vals[2]);
        load_const(5'd5, 32'h11);
        load_const(5'd6, 32'h22);
        foreach (conds[c]) begin
            for (int p = 0; p < 3; p++) begin
                ra = (p == 1) ? 5'd2 : 5'd1;
                rb = (p == 0) ? 5'd2 : 5'd1;
                base = 12'h200 + 12'(12 * k);
                emit(b_type(13'd12, rb, ra, conds[c]));
                store_at(5'd5, base);
                store_at(5'd5, base + 12'd4);
                store_at(5'd6, base + 12'd8);
                if (branch_taken(conds[c], vals[ra], vals[rb])) begin
                    taken++;
                end else begin
                    expect_store({20'd0, base}, 32'h11);
                    expect_store({20'd0, base + 12'd4}, 32'h11);
                end
                expect_store({20'd0, base + 12'd8}, 32'h22);
                k++;
            end
        end
        emit_tail();
        xfer_status.flush    = 1'b1;
        xfer_status.br_taken = 1'b1;
        run_program();
        check_word("flush count", flushes, taken);
    endtask

    task automatic jump_test();
        logic [31:0] tgt;
        begin_test();
        emit(j_type(21'd12, 5'd1));
        store_at(5'd0, 12'h300);
        store_at(5'd0, 12'h304);
        store_at(5'd1, 12'h308);
        expect_store(32'h308, 32'd4);
        // odd address, jalr must drop bit 0
        tgt = 32'(plen * 4 + 16);
        emit(i_type(tgt[11:0] + 12'd1, 5'd0, 3'b000, 5'd2, 7'b0010011));
        emit(i_type(12'd0, 5'd2, 3'b000, 5'd3, 7'b1100111));
        store_at(5'd0, 12'h30C);
        store_at(5'd0, 12'h310);
        store_at(5'd3, 12'h314);
        expect_store(32'h314, tgt - 32'd8);
        emit_tail();
        xfer_status.flush = 1'b1;
        xfer_status.jump  = 1'b1;
        run_program();
        check_word("flush count", flushes, 32'd2);
    endtask

    task automatic x0_test();
        begin_test();
        emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
        store_at(5'd0, 12'h080);
        emit({20'h12345, 5'd0, 7'b0110111});
        emit(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd7));
        store_at(5'd7, 12'h084);
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd8, 7'b0010011));
        emit(i_type(12'd1, 5'd8, 3'b000, 5'd0, 7'b0010011));
        store_at(5'd0, 12'h088);
        expect_store(32'h80, 32'd0);
        expect_store(32'h84, 32'd0);
        expect_store(32'h88, 32'd0);
        emit_tail();
        run_program();
    endtask

    initial begin
        rst_n_i = 1'b0;
        running = 1'b0;
        errors  = 0;
        cycles  = 0;
        budget  = 200;
        void'($urandom(32'h8bd176ed));
        alu_test();
        load_use_test();
        branch_test();
        jump_test();
        x0_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core_props.sv */
`default_nettype none
`include "rv_macros.svh"

module rv_core_props import rv_pkg::*; (
    input logic                clk,
    input logic                rst_n_i,
    input logic                r_en_o,
    input logic                w_en_o,
    input status_t             status_o,
    input logic [`RV_XLEN-1:0] pc_q,
    input logic [`RV_XLEN-1:0] ex_target
);
    timeunit 1ns;
    timeprecision 1ps;

    no_mem_in_reset: assert property (@(posedge clk) !rst_n_i |-> (!r_en_o && !w_en_o))
        else $error("memory enable seen during reset");

    // a redirect wins over a pending load-use stall
    flush_loads_target: assert property (@(posedge clk) disable iff (!rst_n_i)
        status_o.flush |=> (pc_q == $past(ex_target)))
        else $error("pc missed the redirect target");

    pc_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        status_o.stall |=> (pc_q == $past(pc_q)))
        else $error("pc moved during a stall");

    // the bubble behind a stall cannot stall again
    stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        status_o.stall |=> !status_o.stall)
        else $error("stall held for more than one cycle");

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    output logic [`RV_XLEN-1:0] rom_addr_o,
    input  logic [31:0]         instr_i,
    output logic [`RV_XLEN-1:0] ram_addr_o,
    output logic [`RV_XLEN-1:0] store_data_o,
    input  logic [`RV_XLEN-1:0] load_data_i,
    output logic                r_en_o,
    output logic                w_en_o,
    output status_t             status_o
);

    ctrl_t  ctrl;
    instr_u dec_instr;

    // decode-stage word goes out, its control comes back the same cycle
    rv_control u_control (
        .instr_i (dec_instr),
        .ctrl_o  (ctrl)
    );

    rv_datapath u_datapath (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rom_addr_o   (rom_addr_o),
        .instr_i      (instr_i),
        .ctrl_i       (ctrl),
        .dec_instr_o  (dec_instr),
        .ram_addr_o   (ram_addr_o),
        .store_data_o (store_data_o),
        .load_data_i  (load_data_i),
        .r_en_o       (r_en_o),
        .w_en_o       (w_en_o),
        .status_o     (status_o)
    );

endmodule

`default_nettype wire

/* rv_datapath.sv */
`default_nettype none
`include "rv_macros.svh"

module rv_datapath import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    output logic [`RV_XLEN-1:0] rom_addr_o,
    input  logic [31:0]         instr_i,
    input  ctrl_t               ctrl_i,
    output instr_u              dec_instr_o,
    output logic [`RV_XLEN-1:0] ram_addr_o,
    output logic [`RV_XLEN-1:0] store_data_o,
    input  logic [`RV_XLEN-1:0] load_data_i,
    output logic                r_en_o,
    output logic                w_en_o,
    output status_t             status_o
);

    logic [`RV_XLEN-1:0] pc_q;
    if_id_t              if_id_q;
    id_ex_t              id_ex_q;
    ex_mem_t             ex_mem_q;
    mem_wb_t             mem_wb_q;

    logic [31:0]         dec_word;
    logic [`RV_XLEN-1:0] imm_d;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                load_use;
    logic                stall;
    logic                flush;

    logic [`RV_XLEN-1:0] ex_result;
    logic [`RV_XLEN-1:0] ex_store_data;
    logic [`RV_XLEN-1:0] ex_target;
    logic                ex_redirect;

    //////////////////////////////
    // fetch

    assign rom_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (flush) begin
            pc_q <= ex_target;
        end else if (!stall) begin
            pc_q <= pc_q + `RV_XLEN'(4);
        end
    end

    // a zero word decodes as a bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_q <= '0;
        end else if (flush) begin
            if_id_q <= '0;
        end else if (!stall) begin
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= instr_i;
        end
    end

    //////////////////////////////
    // decode

    assign dec_instr_o = if_id_q.instr;
    assign dec_word    = if_id_q.instr;

    always_comb begin
        case (ctrl_i.imm_sel)
            IMM_S:   imm_d = {{20{if_id_q.instr.s.imm_hi[6]}},
                              if_id_q.instr.s.imm_hi, if_id_q.instr.s.imm_lo};
            IMM_B:   imm_d = {{19{dec_word[31]}}, dec_word[31], dec_word[7],
                              dec_word[30:25], dec_word[11:8], 1'b0};
            IMM_U:   imm_d = {dec_word[31:12], 12'h000};
            IMM_J:   imm_d = {{11{dec_word[31]}}, dec_word[31], dec_word[19:12],
                              dec_word[20], dec_word[30:21], 1'b0};
            default: imm_d = {{20{if_id_q.instr.i.imm12[11]}}, if_id_q.instr.i.imm12};
        endcase
    end

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (if_id_q.instr.r.rs1),
        .rs2_i      (if_id_q.instr.r.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (mem_wb_q)
    );

    // only real source operands can cause a load-use stall
    assign uses_rs1 = !ctrl_i.jal && (ctrl_i.imm_sel != IMM_U);
    assign uses_rs2 = !ctrl_i.src_b_imm || ctrl_i.mem_write || ctrl_i.branch;

    assign load_use = id_ex_q.ctrl.mem_read && (id_ex_q.rd != 5'd0) &&
                      ((uses_rs1 && (id_ex_q.rd == if_id_q.instr.r.rs1)) ||
                       (uses_rs2 && (id_ex_q.rd == if_id_q.instr.r.rs2)));

    // flush wins over stall
    assign flush = ex_redirect;
    assign stall = load_use && !flush;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (flush || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q.ctrl     <= ctrl_i;
            id_ex_q.pc       <= if_id_q.pc;
            id_ex_q.rs1      <= if_id_q.instr.r.rs1;
            id_ex_q.rs2      <= if_id_q.instr.r.rs2;
            id_ex_q.rs1_data <= rs1_data;
            id_ex_q.rs2_data <= rs2_data;
            id_ex_q.imm      <= imm_d;
            id_ex_q.rd       <= if_id_q.instr.r.rd;
        end
    end

    //////////////////////////////
    // execute

    rv_ex_stage u_ex_stage (
        .ex_i         (id_ex_q),
        .mem_fwd_i    (ex_mem_q),
        .wb_fwd_i     (mem_wb_q),
        .result_o     (ex_result),
        .store_data_o (ex_store_data),
        .redirect_o   (ex_redirect),
        .target_o     (ex_target)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.reg_write  <= id_ex_q.ctrl.reg_write;
            ex_mem_q.mem_read   <= id_ex_q.ctrl.mem_read;
            ex_mem_q.mem_write  <= id_ex_q.ctrl.mem_write;
            ex_mem_q.rd         <= id_ex_q.rd;
            ex_mem_q.result     <= ex_result;
            ex_mem_q.store_data <= ex_store_data;
        end
    end

    //////////////////////////////
    // memory and writeback

    assign ram_addr_o   = ex_mem_q.result;
    assign store_data_o = ex_mem_q.store_data;
    assign r_en_o       = ex_mem_q.mem_read;
    assign w_en_o       = ex_mem_q.mem_write;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.reg_write <= ex_mem_q.reg_write;
            mem_wb_q.rd        <= ex_mem_q.rd;
            mem_wb_q.data      <= ex_mem_q.mem_read ? load_data_i : ex_mem_q.result;
        end
    end

    assign status_o.stall    = stall;
    assign status_o.flush    = flush;
    assign status_o.br_taken = flush && id_ex_q.ctrl.branch;
    assign status_o.jump     = flush && (id_ex_q.ctrl.jal || id_ex_q.ctrl.jalr);

endmodule

`default_nettype wire

/* rv_ex_stage.sv */
`default_nettype none
`include "rv_macros.svh"

module rv_ex_stage import rv_pkg::*; (
    input  id_ex_t              ex_i,
    input  ex_mem_t             mem_fwd_i,
    input  mem_wb_t             wb_fwd_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic [`RV_XLEN-1:0] store_data_o,
    output logic                redirect_o,
    output logic [`RV_XLEN-1:0] target_o
);

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] link;
    logic                take;

    // the memory stage holds the younger value, so it is checked first
    function automatic logic [`RV_XLEN-1:0] fwd(
        input logic [4:0]          idx,
        input logic [`RV_XLEN-1:0] reg_val,
        input ex_mem_t             m,
        input mem_wb_t             w
    );
        logic [`RV_XLEN-1:0] val;
        val = reg_val;
        if (m.reg_write && (m.rd != 5'd0) && (m.rd == idx)) begin
            val = m.result;
        end else if (w.reg_write && (w.rd != 5'd0) && (w.rd == idx)) begin
            val = w.data;
        end
        return val;
    endfunction

    assign rs1_val = fwd(ex_i.rs1, ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd(ex_i.rs2, ex_i.rs2_data, mem_fwd_i, wb_fwd_i);

    assign op_a = ex_i.ctrl.src_a_pc  ? ex_i.pc  : rs1_val;
    assign op_b = ex_i.ctrl.src_b_imm ? ex_i.imm : rs2_val;

    //////////////////////////////
    // alu

    always_comb begin
        case (ex_i.ctrl.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // branch compare, funct3 encoding
    always_comb begin
        case (ex_i.ctrl.cond)
            3'b000:  take = (rs1_val == rs2_val);
            3'b001:  take = (rs1_val != rs2_val);
            3'b100:  take = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  take = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  take = (rs1_val < rs2_val);
            3'b111:  take = (rs1_val >= rs2_val);
            default: take = 1'b0;
        endcase
    end

    assign link     = ex_i.pc + `RV_XLEN'(4);
    assign result_o = (ex_i.ctrl.jal || ex_i.ctrl.jalr) ? link : alu_out;

    assign store_data_o = rs2_val;

    assign redirect_o = ex_i.ctrl.jal || ex_i.ctrl.jalr || (ex_i.ctrl.branch && take);

    // jalr drops bit 0, pc-relative targets already have it clear
    assign target_o = {alu_out[`RV_XLEN-1:1], alu_out[0] & ~ex_i.ctrl.jalr};

endmodule

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none
`include "rv_macros.svh"

module rv_regfile import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    output logic [`RV_XLEN-1:0] rs1_data_o,
    output logic [`RV_XLEN-1:0] rs2_data_o,
    input  mem_wb_t             wb_i
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    // x0 is never written so it keeps its reset zero
    assign wr_en = wb_i.reg_write && (wb_i.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-before-read bypass
    assign rs1_data_o = (wr_en && (wb_i.rd == rs1_i)) ? wb_i.data : regs[rs1_i];
    assign rs2_data_o = (wr_en && (wb_i.rd == rs2_i)) ? wb_i.data : regs[rs2_i];

endmodule

`default_nettype wire

/* rv_control.sv */
`default_nettype none

module rv_control import rv_pkg::*; (
    input  instr_u instr_i,
    output ctrl_t  ctrl_o
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [2:0] f3;
    logic       alt;

    assign f3 = instr_i.r.funct3;

    // bit 30 means sub or sra, immediates only honor it on shifts
    assign alt = instr_i.r.funct7[5] &&
                 ((instr_i.r.opcode == OP_REG) || (f3 == 3'b101));

    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sel);
        alu_op_e op;
        case (funct3)
            3'b000:  op = sel ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sel ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // unknown opcodes fall through as a bubble
        ctrl_o = '0;
        case (instr_i.r.opcode)
            OP_REG: begin
                ctrl_o.alu_op    = alu_decode(f3, alt);
                ctrl_o.reg_write = 1'b1;
            end
            OP_IMM: begin
                ctrl_o.alu_op    = alu_decode(f3, alt);
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_write = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.alu_op    = ALU_PASS_B;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.imm_sel   = IMM_U;
            end
            OP_LOAD: begin
                // word access only
                if (f3 == 3'b010) begin
                    ctrl_o.src_b_imm = 1'b1;
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                end
            end
            OP_STORE: begin
                if (f3 == 3'b010) begin
                    ctrl_o.src_b_imm = 1'b1;
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.imm_sel   = IMM_S;
                end
            end
            OP_BRANCH: begin
                // alu forms pc + imm as the target
                ctrl_o.src_a_pc  = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.branch    = 1'b1;
                ctrl_o.cond      = f3;
                ctrl_o.imm_sel   = IMM_B;
            end
            OP_JAL: begin
                ctrl_o.src_a_pc  = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.jal       = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.imm_sel   = IMM_J;
            end
            OP_JALR: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.jalr      = 1'b1;
                ctrl_o.reg_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none
`include "rv_macros.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // one instruction word seen through each encoding format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       src_a_pc;
        logic       src_b_imm;
        logic       branch;
        logic [2:0] cond;
        logic       jal;
        logic       jalr;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        imm_sel_e   imm_sel;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        instr_u              instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
    } id_ex_t;

    typedef struct packed {
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                reg_write;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } mem_wb_t;

    typedef struct packed {
        logic stall;
        logic flush;
        logic br_taken;
        logic jump;
    } status_t;

endpackage

`default_nettype wire

/* rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

`define RV_RESET_PC 32'h0000_0000

`endif
